// ==== design/bus_defines.svh ====
// ******************************
// Sizing macros for the shared bus subsystem. Included by
// both packages and by modules that size ports or memories
// ******************************
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Every burst moves exactly this many beats
`define BURST_LEN 8

// One byte per beat
`define DATA_W 8

// Bytes held by each target, addresses wrap at this depth
`define MEM_DEPTH 16
`define ADDR_W 4

`define NUM_TARGETS 2

`endif

// ==== design/bus_interconnect.sv ====
// ******************************
// Round-robin arbiter and bus multiplexer joining two masters
// and two targets
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_interconnect
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire [1:0]                    req,
	output logic [1:0]                   gnt,
	input  wire bus_pkg::master_drive_t  m_drive0,
	input  wire bus_pkg::master_drive_t  m_drive1,
	output bus_pkg::master_drive_t       bus,
	input  wire bus_pkg::target_drive_t  t_drive0,
	input  wire bus_pkg::target_drive_t  t_drive1,
	output logic [`NUM_TARGETS-1:0]      trdy,
	output logic [`DATA_W-1:0]           data_o
);
	import bus_pkg::*;

	localparam master_drive_t IDLE_DRIVE = '{frame: 1'b1, irdy: 1'b1, word: '0};

	logic owner;  // Current or most recent owner
	logic pick;

	// On a tie the master that did not own the bus last wins
	assign pick = (req == 2'b00) ? !owner : req[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gnt <= 2'b11;
			owner <= 1'b1;  // Master 0 wins the first tie
		end
		else if (gnt != 2'b11)
		begin
			if (req[owner])
				gnt <= 2'b11;
		end
		else if (req != 2'b11)
		begin
			gnt <= ~(2'b01 << pick);
			owner <= pick;
		end
	end

	assign bus = (gnt != 2'b11) ? (owner ? m_drive1 : m_drive0) : IDLE_DRIVE;

	assign trdy = {t_drive1.trdy, t_drive0.trdy};

	// Read data comes from whichever target has trdy low
	always_comb
	begin
		if (!t_drive0.trdy)
			data_o = t_drive0.data_o;
		else if (!t_drive1.trdy)
			data_o = t_drive1.data_o;
		else
			data_o = '0;
	end

endmodule

`default_nettype wire

// ==== design/bus_master.sv ====
// ******************************
// Bus master. Takes one burst command, runs it on the shared
// bus and hands back one completion response
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_master
(
	input  wire                         clk,
	input  wire                         reset,
	input  wire xfer_pkg::xfer_cmd_t    cmd,
	input  wire                         cmd_valid,
	output logic                        cmd_ready,
	output xfer_pkg::xfer_rsp_t         rsp,
	output logic                        rsp_valid,
	input  wire                         rsp_ready,
	output logic                        req,
	input  wire                         gnt,
	output bus_pkg::master_drive_t      drive,
	input  wire [`NUM_TARGETS-1:0]      trdy,
	input  wire [`DATA_W-1:0]           data_o
);
	import xfer_pkg::*;
	import bus_pkg::*;

	localparam int CNT_W = $clog2(`BURST_LEN);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_REQUEST,
		S_ADDRESS,
		S_WAIT,
		S_SETTLE,
		S_DATA,
		S_RESPOND
	} state_t;

	state_t                        state;
	xfer_cmd_t                     cmd_q;
	bus_word_t                     word_q;
	logic [CNT_W-1:0]              cnt;      // Settle cycles, then beat number
	logic [CNT_W-1:0]              cnt_nxt;
	logic [`BURST_LEN*`DATA_W-1:0] rdata;
	logic                          on_bus;

	// Byte to send on a given beat, reads put zero on the bus
	function automatic logic [`DATA_W-1:0] wbyte(input logic [CNT_W-1:0] idx);
		return cmd_q.rw ? cmd_q.wdata[idx*`DATA_W +: `DATA_W] : '0;
	endfunction

	assign cnt_nxt = cnt + 1'b1;

	// ******************************
	// Burst sequencing
	// ******************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (cmd_valid)
						state <= S_REQUEST;
				S_REQUEST:
					if (!gnt)
						state <= S_ADDRESS;  // Edge T
				S_ADDRESS:
					state <= S_WAIT;         // Target samples the address here
				S_WAIT:
					if (!trdy[cmd_q.sel])
					begin
						state <= S_SETTLE;
						cnt <= '0;
					end
				S_SETTLE:
				begin
					// Two idle cycles after trdy, as the bus expects
					if (cnt == CNT_W'(1))
					begin
						state <= S_DATA;
						cnt <= '0;
					end
					else
						cnt <= cnt_nxt;
				end
				S_DATA:
				begin
					if (cnt == CNT_W'(`BURST_LEN - 1))
						state <= S_RESPOND;  // Bus released on this edge
					else
						cnt <= cnt_nxt;
				end
				S_RESPOND:
					if (rsp_ready)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Command, bus word and read data
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && cmd_valid)
			cmd_q <= cmd;
		if (state == S_REQUEST && !gnt)
			word_q.addr_phase <= '{rw: cmd_q.rw, sel: cmd_q.sel, rsvd: '0, addr: cmd_q.addr};
		if (state == S_SETTLE && cnt == CNT_W'(1))
			word_q.data_phase <= '{rw: cmd_q.rw, data: wbyte('0)};
		if (state == S_DATA)
		begin
			if (!cmd_q.rw)
				rdata[cnt*`DATA_W +: `DATA_W] <= data_o;  // Target drove this beat last cycle
			word_q.data_phase <= '{rw: cmd_q.rw, data: wbyte(cnt_nxt)};
		end
	end

	// ******************************
	// Outputs decoded from state
	// ******************************
	assign on_bus = (state == S_ADDRESS) || (state == S_WAIT) ||
		(state == S_SETTLE) || (state == S_DATA);

	assign cmd_ready = (state == S_IDLE);
	assign rsp_valid = (state == S_RESPOND);
	assign req = (state == S_IDLE) || (state == S_RESPOND);
	assign drive = '{frame: !on_bus, irdy: !on_bus, word: word_q};

	// Held steady while the response waits, the command register only loads in idle
	assign rsp = '{rw: cmd_q.rw, sel: cmd_q.sel, addr: cmd_q.addr,
		data: cmd_q.rw ? cmd_q.wdata : rdata};

endmodule

`default_nettype wire

// ==== design/bus_pkg.sv ====
// ******************************
// Bus-level types shared by masters, interconnect and targets
// ******************************
`default_nettype none
`include "bus_defines.svh"

package bus_pkg;

	// First word of a burst, carries the target select and start address
	typedef struct packed {
		logic               rw;    // 1 means write
		logic               sel;   // Target select
		logic [2:0]         rsvd;
		logic [`ADDR_W-1:0] addr;  // Start address
	} addr_phase_t;

	// Every later word of a burst
	typedef struct packed {
		logic               rw;
		logic [`DATA_W-1:0] data;
	} data_phase_t;

	// The same 9-bit bus word, read according to the phase of the burst
	typedef union packed {
		addr_phase_t addr_phase;
		data_phase_t data_phase;
	} bus_word_t;

	typedef struct packed {
		logic      frame;  // Active low
		logic      irdy;   // Active low
		bus_word_t word;
	} master_drive_t;

	typedef struct packed {
		logic               trdy;  // Active low
		logic [`DATA_W-1:0] data_o;
	} target_drive_t;

endpackage

`default_nettype wire

// ==== design/bus_target.sv ====
// ******************************
// Memory target. Decodes the address phase for its own select
// and serves an eight-beat write or read burst
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_target
#(
	parameter bit TARGET_ID = 1'b0
)
(
	input  wire                         clk,
	input  wire                         reset,
	input  wire bus_pkg::master_drive_t bus,
	output bus_pkg::target_drive_t      drive
);
	// Counted from the edge trdy falls. Reads drive one cycle ahead of writes
	localparam int RD_FIRST = 2;
	localparam int WR_FIRST = 3;
	localparam int LAST = WR_FIRST + `BURST_LEN - 1;
	localparam int CNT_W = $clog2(LAST + 1);

	typedef enum logic [1:0]
	{
		T_IDLE,
		T_DECODE,
		T_ACTIVE
	} state_t;

	state_t             state;
	logic [CNT_W-1:0]   cnt;
	logic               rw_q;
	logic [`ADDR_W-1:0] ptr;   // Wraps at the memory depth
	logic [`DATA_W-1:0] data_q;
	logic [`DATA_W-1:0] mem [`MEM_DEPTH];
	logic               frame_q;  // Frame as seen on the previous edge
	logic               hit;
	logic               rd_beat;
	logic               wr_beat;

	// The address phase is only the first cycle of frame low
	assign hit = (state == T_IDLE) && !bus.frame && frame_q &&
		(bus.word.addr_phase.sel == TARGET_ID);

	assign rd_beat = (state == T_ACTIVE) && !rw_q &&
		(cnt >= CNT_W'(RD_FIRST)) && (cnt < CNT_W'(RD_FIRST + `BURST_LEN));
	assign wr_beat = (state == T_ACTIVE) && rw_q && !bus.irdy &&
		(cnt >= CNT_W'(WR_FIRST)) && (cnt <= CNT_W'(LAST));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= T_IDLE;
			cnt <= '0;
			frame_q <= 1'b1;
		end
		else
		begin
			frame_q <= bus.frame;
			case (state)
				T_IDLE:
					if (hit)
						state <= T_DECODE;
				T_DECODE:
				begin
					state <= T_ACTIVE;  // trdy falls here
					cnt <= '0;
				end
				T_ACTIVE:
				begin
					if (cnt == CNT_W'(LAST))
						state <= T_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= T_IDLE;
			endcase
		end
	end

	// Address phase capture and the wrapping beat pointer
	always_ff @(posedge clk)
	begin
		if (hit)
		begin
			rw_q <= bus.word.addr_phase.rw;
			ptr <= bus.word.addr_phase.addr;
		end
		else if (rd_beat || wr_beat)
			ptr <= ptr + 1'b1;
		if (rd_beat)
			data_q <= mem[ptr];
	end

	// ******************************
	// Storage, cleared by reset so untouched bytes read as zero
	// ******************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_beat)
			mem[ptr] <= bus.word.data_phase.data;
	end

	assign drive = '{trdy: (state != T_ACTIVE), data_o: data_q};

endmodule

`default_nettype wire

// ==== design/bus_top.sv ====
// ******************************
// Two masters, one interconnect and two memory targets
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_top
(
	input  wire                      clk,
	input  wire                      reset,
	input  wire xfer_pkg::xfer_cmd_t cmd0,
	input  wire                      cmd0_valid,
	output logic                     cmd0_ready,
	input  wire xfer_pkg::xfer_cmd_t cmd1,
	input  wire                      cmd1_valid,
	output logic                     cmd1_ready,
	output xfer_pkg::xfer_rsp_t      rsp0,
	output logic                     rsp0_valid,
	input  wire                      rsp0_ready,
	output xfer_pkg::xfer_rsp_t      rsp1,
	output logic                     rsp1_valid,
	input  wire                      rsp1_ready
);
	import bus_pkg::*;

	logic [1:0]              req;
	logic [1:0]              gnt;
	master_drive_t           m_drive0;
	master_drive_t           m_drive1;
	master_drive_t           bus;
	target_drive_t           t_drive0;
	target_drive_t           t_drive1;
	logic [`NUM_TARGETS-1:0] trdy;
	logic [`DATA_W-1:0]      data_o;

	bus_master master0_i
	(
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd0),
		.cmd_valid (cmd0_valid),
		.cmd_ready (cmd0_ready),
		.rsp       (rsp0),
		.rsp_valid (rsp0_valid),
		.rsp_ready (rsp0_ready),
		.req       (req[0]),
		.gnt       (gnt[0]),
		.drive     (m_drive0),
		.trdy      (trdy),
		.data_o    (data_o)
	);

	bus_master master1_i
	(
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd1),
		.cmd_valid (cmd1_valid),
		.cmd_ready (cmd1_ready),
		.rsp       (rsp1),
		.rsp_valid (rsp1_valid),
		.rsp_ready (rsp1_ready),
		.req       (req[1]),
		.gnt       (gnt[1]),
		.drive     (m_drive1),
		.trdy      (trdy),
		.data_o    (data_o)
	);

	bus_interconnect bus_i
	(
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.gnt      (gnt),
		.m_drive0 (m_drive0),
		.m_drive1 (m_drive1),
		.bus      (bus),
		.t_drive0 (t_drive0),
		.t_drive1 (t_drive1),
		.trdy     (trdy),
		.data_o   (data_o)
	);

	bus_target #(.TARGET_ID(1'b0)) target0_i
	(
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.drive (t_drive0)
	);

	bus_target #(.TARGET_ID(1'b1)) target1_i
	(
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.drive (t_drive1)
	);

endmodule

`default_nettype wire

// ==== design/xfer_pkg.sv ====
// ******************************
// Command and response words on the user side of a bus master
// ******************************
`default_nettype none
`include "bus_defines.svh"

package xfer_pkg;

	// One burst request. Byte k of wdata goes to address (addr + k) mod depth
	typedef struct packed {
		logic                          rw;     // 1 means write
		logic                          sel;    // Target 0 or 1
		logic [`ADDR_W-1:0]            addr;
		logic [`BURST_LEN*`DATA_W-1:0] wdata;
	} xfer_cmd_t;

	// Completion of one burst
	typedef struct packed {
		logic                          rw;
		logic                          sel;
		logic [`ADDR_W-1:0]            addr;
		logic [`BURST_LEN*`DATA_W-1:0] data;   // Bytes read, or bytes written
	} xfer_rsp_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+design
design/bus_pkg.sv
design/xfer_pkg.sv
design/bus_master.sv
design/bus_interconnect.sv
design/bus_target.sv
design/bus_top.sv
tests/bus_chk.sv
tests/bus_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bus testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module bus_top_tb -f files.f -o bus_top_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/bus_top_tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tests/bus_chk.sv ====
// ******************************
// Bus protocol assertions. Bound into the interconnect by the
// testbench, which reads fail_count at the end of the run
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_chk
(
	input wire                         clk,
	input wire                         reset,
	input wire [1:0]                   gnt,
	input wire bus_pkg::master_drive_t m_drive0,
	input wire bus_pkg::master_drive_t m_drive1,
	input wire [`NUM_TARGETS-1:0]      trdy
);
	int fail_count = 0;

	// Only one master may own the bus at a time
	no_double_grant: assert property (@(posedge clk) disable iff (reset) gnt != 2'b00)
	else
	begin
		fail_count++;
		$error("both grants low at once");
	end

	// A master drives frame only while it holds its own grant
	frame0_needs_grant: assert property (@(posedge clk) disable iff (reset)
		!m_drive0.frame |-> !gnt[0])
	else
	begin
		fail_count++;
		$error("master 0 frame low without its grant");
	end

	frame1_needs_grant: assert property (@(posedge clk) disable iff (reset)
		!m_drive1.frame |-> !gnt[1])
	else
	begin
		fail_count++;
		$error("master 1 frame low without its grant");
	end

	one_trdy: assert property (@(posedge clk) disable iff (reset) $countones(~trdy) <= 1)
	else
	begin
		fail_count++;
		$error("more than one trdy low");
	end

	// ******************************
	// trdy stays low for settle plus eight beats
	// ******************************
	trdy0_width: assert property (@(posedge clk) disable iff (reset)
		$fell(trdy[0]) |-> ##11 $rose(trdy[0]))
	else
	begin
		fail_count++;
		$error("target 0 trdy low for the wrong number of cycles");
	end

	trdy1_width: assert property (@(posedge clk) disable iff (reset)
		$fell(trdy[1]) |-> ##11 $rose(trdy[1]))
	else
	begin
		fail_count++;
		$error("target 1 trdy low for the wrong number of cycles");
	end

endmodule

`default_nettype wire

// ==== tests/bus_top_tb.sv ====
// ******************************
// Directed testbench for the two-master bus subsystem. Keeps a
// byte model of both targets and checks every response
// ******************************
`default_nettype none
`include "bus_defines.svh"

module bus_top_tb;
	import xfer_pkg::*;

	localparam int MAX_CYCLES = 2000;  // Six tests need under 600 cycles

	logic      clk;
	logic      reset;
	xfer_cmd_t cmd0;
	xfer_cmd_t cmd1;
	logic      cmd0_valid;
	logic      cmd1_valid;
	logic      cmd0_ready;
	logic      cmd1_ready;
	xfer_rsp_t rsp0;
	xfer_rsp_t rsp1;
	logic      rsp0_valid;
	logic      rsp1_valid;
	logic      rsp0_ready;
	logic      rsp1_ready;

	int seed = 32'h71ff;
	int err_count = 0;
	int err_mark = 0;
	int n_checks = 0;
	int n_tests = 0;
	int cycles = 0;

	logic [`DATA_W-1:0] model_mem [`NUM_TARGETS][`MEM_DEPTH];  // Expected target contents

	bus_top dut_i
	(
		.clk        (clk),
		.reset      (reset),
		.cmd0       (cmd0),
		.cmd0_valid (cmd0_valid),
		.cmd0_ready (cmd0_ready),
		.cmd1       (cmd1),
		.cmd1_valid (cmd1_valid),
		.cmd1_ready (cmd1_ready),
		.rsp0       (rsp0),
		.rsp0_valid (rsp0_valid),
		.rsp0_ready (rsp0_ready),
		.rsp1       (rsp1),
		.rsp1_valid (rsp1_valid),
		.rsp1_ready (rsp1_ready)
	);

	bind bus_interconnect bus_chk chk_i
	(
		.clk      (clk),
		.reset    (reset),
		.gnt      (gnt),
		.m_drive0 (m_drive0),
		.m_drive1 (m_drive1),
		.trdy     (trdy)
	);

	always #20 clk = ~clk;

	// ******************************
	// Stimulus helpers and model
	// ******************************
	function automatic logic [63:0] rand_bytes();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic xfer_cmd_t make_cmd(input logic rw, input logic sel,
		input logic [`ADDR_W-1:0] addr, input logic [63:0] wdata);
		xfer_cmd_t c;
		c.rw = rw;
		c.sel = sel;
		c.addr = addr;
		c.wdata = rw ? wdata : '0;
		return c;
	endfunction

	// Applies a write to the model and returns the response the burst should give
	function automatic xfer_rsp_t predict(input xfer_cmd_t c);
		xfer_rsp_t r;
		logic [`ADDR_W-1:0] a;
		r.rw = c.rw;
		r.sel = c.sel;
		r.addr = c.addr;
		r.data = '0;
		for (int k = 0; k < `BURST_LEN; k++)
		begin
			a = c.addr + `ADDR_W'(k);  // Wraps at the memory depth
			if (c.rw)
				model_mem[c.sel][a] = c.wdata[k*`DATA_W +: `DATA_W];
			r.data[k*`DATA_W +: `DATA_W] = model_mem[c.sel][a];
		end
		return r;
	endfunction

	task automatic check_rsp(input xfer_rsp_t got, input xfer_rsp_t exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			err_count++;
			$display("Error at %0t: %s, expected rw %b sel %b addr %h data %h",
				$time, what, exp.rw, exp.sel, exp.addr, exp.data);
			$display("Error at %0t: %s, got rw %b sel %b addr %h data %h",
				$time, what, got.rw, got.sel, got.addr, got.data);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			err_count++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic send_cmd(input bit m, input xfer_cmd_t c);
		@(negedge clk);
		if (m)
		begin
			cmd1 = c;
			cmd1_valid = 1'b1;
		end
		else
		begin
			cmd0 = c;
			cmd0_valid = 1'b1;
		end
		while (!(m ? cmd1_ready : cmd0_ready))
			@(negedge clk);
		@(negedge clk);  // Accepted on the edge just passed
		cmd0_valid = 1'b0;
		cmd1_valid = 1'b0;
	endtask

	task automatic collect_rsp(input bit m, output xfer_rsp_t r);
		@(negedge clk);
		while (!(m ? rsp1_valid : rsp0_valid))
			@(negedge clk);
		r = m ? rsp1 : rsp0;
	endtask

	task automatic run_burst(input bit m, input xfer_cmd_t c, input string what);
		xfer_rsp_t exp;
		xfer_rsp_t got;
		exp = predict(c);
		send_cmd(m, c);
		collect_rsp(m, got);
		check_rsp(got, exp, what);
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		$display("test %0d %s: %s", n_tests, name, (err_count == err_mark) ? "ok" : "failed");
		err_mark = err_count;
	endtask

	// ******************************
	// Tests
	// ******************************
	task automatic test_write_read();
		run_burst(0, make_cmd(1'b1, 1'b0, 4'd3, rand_bytes()), "write t0@3");
		run_burst(0, make_cmd(1'b0, 1'b0, 4'd3, '0), "read t0@3");
		finish_test("write then read");
	endtask

	task automatic test_targets_independent();
		logic [63:0] a;
		a = rand_bytes();
		run_burst(0, make_cmd(1'b1, 1'b0, 4'd5, a), "write t0@5");
		run_burst(1, make_cmd(1'b1, 1'b1, 4'd5, ~a), "write t1@5");  // Every byte differs
		run_burst(1, make_cmd(1'b0, 1'b0, 4'd5, '0), "read t0@5");
		run_burst(0, make_cmd(1'b0, 1'b1, 4'd5, '0), "read t1@5");
		finish_test("independent targets");
	endtask

	task automatic test_wrap();
		run_burst(0, make_cmd(1'b1, 1'b1, 4'd12, rand_bytes()), "write t1@12");
		run_burst(1, make_cmd(1'b0, 1'b1, 4'd12, '0), "read t1@12");
		run_burst(0, make_cmd(1'b0, 1'b1, 4'd0, '0), "read t1@0");
		finish_test("address wrap");
	endtask

	task automatic run_pair(input xfer_cmd_t c0, input xfer_cmd_t c1, input string what);
		xfer_rsp_t exp0;
		xfer_rsp_t exp1;
		xfer_rsp_t got0;
		xfer_rsp_t got1;
		bit seen0;
		bit seen1;
		exp0 = predict(c0);  // Bursts touch disjoint bytes, so order is free
		exp1 = predict(c1);
		seen0 = 1'b0;
		seen1 = 1'b0;
		@(negedge clk);
		cmd0 = c0;
		cmd1 = c1;
		cmd0_valid = 1'b1;
		cmd1_valid = 1'b1;
		while (!(cmd0_ready && cmd1_ready))
			@(negedge clk);
		@(negedge clk);
		cmd0_valid = 1'b0;
		cmd1_valid = 1'b0;
		while (!(seen0 && seen1))
		begin
			@(negedge clk);
			if (rsp0_valid && !seen0)
			begin
				got0 = rsp0;
				seen0 = 1'b1;
			end
			if (rsp1_valid && !seen1)
			begin
				got1 = rsp1;
				seen1 = 1'b1;
			end
		end
		check_rsp(got0, exp0, {what, " master 0"});
		check_rsp(got1, exp1, {what, " master 1"});
	endtask

	task automatic test_contention();
		run_pair(make_cmd(1'b0, 1'b0, 4'd3, '0), make_cmd(1'b1, 1'b1, 4'd6, rand_bytes()),
			"split targets");
		run_pair(make_cmd(1'b1, 1'b1, 4'd0, rand_bytes()), make_cmd(1'b0, 1'b1, 4'd8, '0),
			"shared target");
		finish_test("contention");
	endtask

	task automatic test_backpressure();
		xfer_rsp_t exp0;
		xfer_rsp_t exp1;
		xfer_rsp_t got;
		xfer_cmd_t c;
		@(negedge clk);
		rsp0_ready = 1'b0;
		c = make_cmd(1'b1, 1'b0, 4'd2, rand_bytes());
		exp0 = predict(c);
		send_cmd(0, c);
		collect_rsp(0, got);
		check_rsp(got, exp0, "held write t0@2");
		// Master 1 reads the bytes master 0 just wrote while master 0 waits
		c = make_cmd(1'b0, 1'b0, 4'd2, '0);
		exp1 = predict(c);
		send_cmd(1, c);
		while (!rsp1_valid)
		begin
			check_ready(rsp0_valid, 1'b1, "rsp0_valid while held");
			check_ready(cmd0_ready, 1'b0, "cmd0_ready while held");
			check_rsp(rsp0, exp0, "rsp0 while held");
			@(negedge clk);
		end
		check_rsp(rsp1, exp1, "read t0@2 by master 1");
		rsp0_ready = 1'b1;
		@(negedge clk);
		check_ready(rsp0_valid, 1'b0, "rsp0_valid after release");
		check_ready(cmd0_ready, 1'b1, "cmd0_ready after release");
		run_burst(0, make_cmd(1'b0, 1'b0, 4'd2, '0), "read t0@2 after release");
		finish_test("response back-pressure");
	endtask

	task automatic test_reset_state();
		xfer_cmd_t c;
		xfer_rsp_t held;
		// Master 0 still holds a response when reset arrives
		@(negedge clk);
		rsp0_ready = 1'b0;
		c = make_cmd(1'b1, 1'b0, 4'd3, rand_bytes());
		send_cmd(0, c);
		collect_rsp(0, held);
		check_rsp(held, predict(c), "held write t0@3 before reset");
		reset = 1'b1;
		rsp0_ready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < `NUM_TARGETS; t++)
			for (int i = 0; i < `MEM_DEPTH; i++)
				model_mem[t][i] = '0;
		check_ready(cmd0_ready, 1'b1, "cmd0_ready after reset");
		check_ready(cmd1_ready, 1'b1, "cmd1_ready after reset");
		check_ready(rsp0_valid, 1'b0, "rsp0_valid after reset");
		check_ready(rsp1_valid, 1'b0, "rsp1_valid after reset");
		run_burst(0, make_cmd(1'b0, 1'b0, 4'd3, '0), "read t0@3 after reset");
		run_burst(1, make_cmd(1'b0, 1'b1, 4'd12, '0), "read t1@12 after reset");
		finish_test("reset state");
	endtask

	// ******************************
	// Run control
	// ******************************
	initial
	begin
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		cmd0 = '0;
		cmd1 = '0;
		cmd0_valid = 1'b0;
		cmd1_valid = 1'b0;
		rsp0_ready = 1'b1;
		rsp1_ready = 1'b1;
		for (int t = 0; t < `NUM_TARGETS; t++)
			for (int i = 0; i < `MEM_DEPTH; i++)
				model_mem[t][i] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_write_read();
		test_targets_independent();
		test_wrap();
		test_contention();
		test_backpressure();
		test_reset_state();

		if (dut_i.bus_i.chk_i.fail_count != 0)
		begin
			$display("Bus protocol assertions failed %0d times", dut_i.bus_i.chk_i.fail_count);
			err_count += dut_i.bus_i.chk_i.fail_count;
		end
		$display("%0d tests, %0d checks, %0d errors, %0d cycles",
			n_tests, n_checks, err_count, cycles);
		if (err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
